/* src/lc4_isa_pkg.sv */
package lc4_isa_pkg;

    typedef logic [15:0] word_t;     // Machine word
    typedef logic [2:0]  reg_sel_t;  // Register index
    typedef logic [2:0]  nzp_t;      // {N, Z, P}

    // Major opcodes in insn[15:12]
    localparam logic [3:0] OPC_ARITH = 4'b0001;
    localparam logic [3:0] OPC_LOGIC = 4'b0101;
    localparam logic [3:0] OPC_CONST = 4'b1001;

    // Sub-operations in insn[5:3], arithmetic group
    localparam logic [2:0] SUB_ADD = 3'b000;
    localparam logic [2:0] SUB_MUL = 3'b001;
    localparam logic [2:0] SUB_SUB = 3'b010;
    // Logic group
    localparam logic [2:0] SUB_AND = 3'b000;
    localparam logic [2:0] SUB_NOT = 3'b001;
    localparam logic [2:0] SUB_OR  = 3'b010;
    localparam logic [2:0] SUB_XOR = 3'b011;

    typedef struct packed {
        logic [3:0] opcode;
        reg_sel_t   rd;
        reg_sel_t   rs;
        logic [2:0] sub;         // Bit 2 doubles as the immediate flag
        reg_sel_t   rt;
    } insn_rr_t;

    typedef struct packed {
        logic [3:0] opcode;
        reg_sel_t   rd;
        reg_sel_t   rs;
        logic       imm_flag;
        logic [4:0] imm5;
    } insn_ri_t;

    typedef struct packed {
        logic [3:0] opcode;
        reg_sel_t   rd;
        logic [8:0] imm9;
    } insn_ci_t;

    // Same 16 bits, three readings
    typedef union packed {
        insn_rr_t rr;
        insn_ri_t ri;
        insn_ci_t ci;
    } insn_u;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_MUL, ALU_AND, ALU_NOT, ALU_OR, ALU_XOR, ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        alu_op_e  alu_op;
        reg_sel_t rs_sel;
        reg_sel_t rt_sel;
        reg_sel_t rd_sel;
        logic     regfile_we;
        logic     use_imm;       // Operand B from imm instead of rt
        word_t    imm;           // Already sign-extended
    } ctrl_t;

endpackage

/* src/lc4_pipe_pkg.sv */
package lc4_pipe_pkg;

    localparam lc4_isa_pkg::word_t RESET_PC = 16'h8200;  // First fetch address
    localparam int NUM_REGS = 8;

    // Fetch to decode
    typedef struct packed {
        logic               valid;
        lc4_isa_pkg::word_t pc;
        lc4_isa_pkg::word_t insn;
    } fd_t;

    // Decode to execute, operands as read from the register file
    typedef struct packed {
        logic               valid;
        lc4_isa_pkg::word_t pc;
        lc4_isa_pkg::word_t insn;
        lc4_isa_pkg::ctrl_t ctrl;
        lc4_isa_pkg::word_t rs_data;
        lc4_isa_pkg::word_t rt_data;
    } dx_t;

    // Result record, shared by memory, writeback and retire
    typedef struct packed {
        logic                  valid;
        lc4_isa_pkg::word_t    pc;
        lc4_isa_pkg::word_t    insn;
        lc4_isa_pkg::reg_sel_t rd;
        logic                  regfile_we;
        lc4_isa_pkg::word_t    result;
        lc4_isa_pkg::nzp_t     nzp;
    } wb_t;

endpackage

/* src/lc4_alu.sv */
`timescale 1ns/100ps

module lc4_alu (
    input  lc4_isa_pkg::alu_op_e i_op,
    input  lc4_isa_pkg::word_t   i_a,
    input  lc4_isa_pkg::word_t   i_b,
    output lc4_isa_pkg::word_t   o_result,
    output lc4_isa_pkg::nzp_t    o_nzp
);

    logic is_zero;

    always_comb begin
        o_result = i_b;
        case (i_op)
            lc4_isa_pkg::ALU_ADD:    o_result = i_a + i_b;
            lc4_isa_pkg::ALU_SUB:    o_result = i_a - i_b;
            lc4_isa_pkg::ALU_MUL:    o_result = i_a * i_b;   // Low 16 bits kept
            lc4_isa_pkg::ALU_AND:    o_result = i_a & i_b;
            lc4_isa_pkg::ALU_NOT:    o_result = ~i_a;
            lc4_isa_pkg::ALU_OR:     o_result = i_a | i_b;
            lc4_isa_pkg::ALU_XOR:    o_result = i_a ^ i_b;
            lc4_isa_pkg::ALU_PASS_B: o_result = i_b;         // CONST
            default:                 o_result = i_b;
        endcase
    end

    // Exactly one of N, Z, P is set
    assign is_zero  = (o_result == 16'h0000);
    assign o_nzp[2] = o_result[15];
    assign o_nzp[1] = is_zero;
    assign o_nzp[0] = ~o_result[15] & ~is_zero;

endmodule

/* src/lc4_decoder.sv */
`timescale 1ns/100ps

module lc4_decoder (
    input  lc4_isa_pkg::insn_u i_insn,
    output lc4_isa_pkg::ctrl_t o_ctrl
);

    always_comb begin
        // Register fields sit at the same place in all kept formats
        o_ctrl.rs_sel     = i_insn.rr.rs;
        o_ctrl.rt_sel     = i_insn.rr.rt;
        o_ctrl.rd_sel     = i_insn.rr.rd;
        o_ctrl.alu_op     = lc4_isa_pkg::ALU_ADD;
        o_ctrl.regfile_we = 1'b0;                         // Unkept words retire as no-ops
        o_ctrl.use_imm    = 1'b0;
        o_ctrl.imm        = {{11{i_insn.ri.imm5[4]}}, i_insn.ri.imm5};  // imm5 sign-extend

        case (i_insn.rr.opcode)
            lc4_isa_pkg::OPC_ARITH: begin
                if (i_insn.ri.imm_flag) begin             // ADD Rd, Rs, #imm5
                    o_ctrl.alu_op     = lc4_isa_pkg::ALU_ADD;
                    o_ctrl.use_imm    = 1'b1;
                    o_ctrl.regfile_we = 1'b1;
                end else begin
                    o_ctrl.regfile_we = 1'b1;
                    case (i_insn.rr.sub)
                        lc4_isa_pkg::SUB_ADD: o_ctrl.alu_op = lc4_isa_pkg::ALU_ADD;
                        lc4_isa_pkg::SUB_MUL: o_ctrl.alu_op = lc4_isa_pkg::ALU_MUL;
                        lc4_isa_pkg::SUB_SUB: o_ctrl.alu_op = lc4_isa_pkg::ALU_SUB;
                        default:              o_ctrl.regfile_we = 1'b0;  // DIV
                    endcase
                end
            end
            lc4_isa_pkg::OPC_LOGIC: begin
                o_ctrl.regfile_we = 1'b1;                 // Every logic form writes
                if (i_insn.ri.imm_flag) begin             // AND Rd, Rs, #imm5
                    o_ctrl.alu_op  = lc4_isa_pkg::ALU_AND;
                    o_ctrl.use_imm = 1'b1;
                end else begin
                    case (i_insn.rr.sub)
                        lc4_isa_pkg::SUB_AND: o_ctrl.alu_op = lc4_isa_pkg::ALU_AND;
                        lc4_isa_pkg::SUB_NOT: o_ctrl.alu_op = lc4_isa_pkg::ALU_NOT;
                        lc4_isa_pkg::SUB_OR:  o_ctrl.alu_op = lc4_isa_pkg::ALU_OR;
                        default:              o_ctrl.alu_op = lc4_isa_pkg::ALU_XOR;
                    endcase
                end
            end
            lc4_isa_pkg::OPC_CONST: begin
                // Rd = sext(imm9), passed straight through the ALU
                o_ctrl.alu_op     = lc4_isa_pkg::ALU_PASS_B;
                o_ctrl.use_imm    = 1'b1;
                o_ctrl.imm        = {{7{i_insn.ci.imm9[8]}}, i_insn.ci.imm9};
                o_ctrl.regfile_we = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

/* src/lc4_regfile.sv */
`timescale 1ns/100ps

module lc4_regfile (
    input  logic                  gwe,
    input  logic                  i_rst,
    input  lc4_isa_pkg::reg_sel_t i_rs_sel,
    input  lc4_isa_pkg::reg_sel_t i_rt_sel,
    output lc4_isa_pkg::word_t    o_rs_data,
    output lc4_isa_pkg::word_t    o_rt_data,
    input  lc4_pipe_pkg::wb_t     i_wb         // Write port from writeback
);

    lc4_isa_pkg::word_t regs [lc4_pipe_pkg::NUM_REGS];

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            for (int i = 0; i < lc4_pipe_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.regfile_we) begin
            regs[i_wb.rd] <= i_wb.result;
        end
    end

    // Write-through covers the producer three slots ahead
    assign o_rs_data = (i_wb.regfile_we && (i_wb.rd == i_rs_sel)) ? i_wb.result
                                                                   : regs[i_rs_sel];
    assign o_rt_data = (i_wb.regfile_we && (i_wb.rd == i_rt_sel)) ? i_wb.result
                                                                   : regs[i_rt_sel];

endmodule

/* src/lc4_fetch.sv */
`timescale 1ns/100ps

module lc4_fetch (
    input  logic               gwe,
    input  logic               i_rst,
    output lc4_isa_pkg::word_t o_cur_pc,
    input  lc4_isa_pkg::word_t i_cur_insn,
    output lc4_pipe_pkg::fd_t  o_fd
);

    lc4_isa_pkg::word_t pc_q;

    // No branches, so the PC only ever steps forward
    always_ff @(posedge gwe) begin
        if (i_rst) begin
            pc_q <= lc4_pipe_pkg::RESET_PC;
        end else begin
            pc_q <= pc_q + 16'd1;
        end
    end

    assign o_cur_pc = pc_q;  // Memory read is combinational

    // F/D register
    always_ff @(posedge gwe) begin
        o_fd.pc   <= pc_q;
        o_fd.insn <= i_cur_insn;
        if (i_rst) begin
            o_fd.valid <= 1'b0;  // Empty slot
        end else begin
            o_fd.valid <= 1'b1;
        end
    end

endmodule

/* src/lc4_decode_stage.sv */
`timescale 1ns/100ps

module lc4_decode_stage (
    input  logic              gwe,
    input  logic              i_rst,
    input  lc4_pipe_pkg::fd_t i_fd,
    input  lc4_pipe_pkg::wb_t i_wb,
    output lc4_pipe_pkg::dx_t o_dx
);

    lc4_isa_pkg::insn_u d_insn;
    lc4_isa_pkg::ctrl_t d_ctrl;
    lc4_isa_pkg::word_t rs_data;
    lc4_isa_pkg::word_t rt_data;

    assign d_insn = i_fd.insn;   // Raw word viewed through the union

    lc4_decoder u_decoder (
        .i_insn (d_insn),
        .o_ctrl (d_ctrl)
    );

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_rst     (i_rst),
        .i_rs_sel  (d_ctrl.rs_sel),
        .i_rt_sel  (d_ctrl.rt_sel),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data),
        .i_wb      (i_wb)
    );

    // D/X register
    always_ff @(posedge gwe) begin
        o_dx.pc      <= i_fd.pc;
        o_dx.insn    <= i_fd.insn;
        o_dx.ctrl    <= d_ctrl;
        o_dx.rs_data <= rs_data;
        o_dx.rt_data <= rt_data;
        if (i_rst) begin
            o_dx.valid           <= 1'b0;
            o_dx.ctrl.regfile_we <= 1'b0;
        end else begin
            o_dx.valid           <= i_fd.valid;
            o_dx.ctrl.regfile_we <= d_ctrl.regfile_we & i_fd.valid;  // Bubble never writes
        end
    end

endmodule

/* src/lc4_execute.sv */
`timescale 1ns/100ps

module lc4_execute (
    input  logic              gwe,
    input  logic              i_rst,
    input  lc4_pipe_pkg::dx_t i_dx,
    input  lc4_pipe_pkg::wb_t i_wb,    // Writeback stage
    output lc4_pipe_pkg::wb_t o_mem    // Memory stage, also bypass source
);

    lc4_isa_pkg::word_t op_a;
    lc4_isa_pkg::word_t rt_fwd;
    lc4_isa_pkg::word_t op_b;
    lc4_isa_pkg::word_t alu_result;
    lc4_isa_pkg::nzp_t  alu_nzp;

    // Youngest producer wins, memory before writeback
    function automatic lc4_isa_pkg::word_t fwd(input lc4_isa_pkg::reg_sel_t sel,
                                               input lc4_isa_pkg::word_t    reg_val,
                                               input lc4_pipe_pkg::wb_t     mem,
                                               input lc4_pipe_pkg::wb_t     wb);
        if (mem.regfile_we && (mem.rd == sel)) begin
            return mem.result;
        end else if (wb.regfile_we && (wb.rd == sel)) begin
            return wb.result;
        end
        return reg_val;                                 // Register file already current
    endfunction

    always_comb begin
        op_a   = fwd(i_dx.ctrl.rs_sel, i_dx.rs_data, o_mem, i_wb);
        rt_fwd = fwd(i_dx.ctrl.rt_sel, i_dx.rt_data, o_mem, i_wb);
        op_b   = i_dx.ctrl.use_imm ? i_dx.ctrl.imm : rt_fwd;   // imm5 or imm9
    end

    lc4_alu u_alu (
        .i_op     (i_dx.ctrl.alu_op),
        .i_a      (op_a),
        .i_b      (op_b),
        .o_result (alu_result),
        .o_nzp    (alu_nzp)
    );

    // X/M register
    always_ff @(posedge gwe) begin
        o_mem.pc     <= i_dx.pc;
        o_mem.insn   <= i_dx.insn;
        o_mem.rd     <= i_dx.ctrl.rd_sel;
        o_mem.result <= alu_result;
        o_mem.nzp    <= alu_nzp;
        if (i_rst) begin
            o_mem.valid      <= 1'b0;
            o_mem.regfile_we <= 1'b0;
        end else begin
            o_mem.valid      <= i_dx.valid;
            o_mem.regfile_we <= i_dx.ctrl.regfile_we;
        end
    end

endmodule

/* src/lc4_writeback.sv */
`timescale 1ns/100ps

module lc4_writeback (
    input  logic              gwe,
    input  logic              i_rst,
    input  lc4_pipe_pkg::wb_t i_mem,
    output lc4_pipe_pkg::wb_t o_wb    // Regfile write, bypass and retire
);

    // M/W register, memory stage has nothing of its own to add
    always_ff @(posedge gwe) begin
        o_wb.pc     <= i_mem.pc;
        o_wb.insn   <= i_mem.insn;
        o_wb.rd     <= i_mem.rd;
        o_wb.result <= i_mem.result;
        o_wb.nzp    <= i_mem.nzp;
        if (i_rst) begin
            o_wb.valid      <= 1'b0;
            o_wb.regfile_we <= 1'b0;   // No stray write after reset
        end else begin
            o_wb.valid      <= i_mem.valid;
            o_wb.regfile_we <= i_mem.regfile_we;
        end
    end

endmodule

/* src/lc4_core.sv */
`timescale 1ns/100ps

module lc4_core (
    input  logic                gwe,         // Global clock
    input  logic                i_rst,
    output lc4_isa_pkg::word_t  o_cur_pc,    // Instruction memory address
    input  lc4_isa_pkg::word_t  i_cur_insn,  // Word at o_cur_pc, same cycle
    output lc4_pipe_pkg::wb_t   o_retire     // Instruction leaving writeback
);

    lc4_pipe_pkg::fd_t fd;   // F/D register
    lc4_pipe_pkg::dx_t dx;   // D/X register
    lc4_pipe_pkg::wb_t mem;  // X/M register
    lc4_pipe_pkg::wb_t wb;   // M/W register

    lc4_fetch u_fetch (
        .gwe        (gwe),
        .i_rst      (i_rst),
        .o_cur_pc   (o_cur_pc),
        .i_cur_insn (i_cur_insn),
        .o_fd       (fd)
    );

    lc4_decode_stage u_decode (
        .gwe   (gwe),
        .i_rst (i_rst),
        .i_fd  (fd),
        .i_wb  (wb),     // Register write port
        .o_dx  (dx)
    );

    lc4_execute u_execute (
        .gwe   (gwe),
        .i_rst (i_rst),
        .i_dx  (dx),
        .i_wb  (wb),     // Second forwarding source
        .o_mem (mem)
    );

    lc4_writeback u_writeback (
        .gwe   (gwe),
        .i_rst (i_rst),
        .i_mem (mem),
        .o_wb  (wb)
    );

    assign o_retire = wb;

endmodule

/* dv/lc4_core_asserts.sv */
`timescale 1ns/100ps

module lc4_core_asserts (
    input logic               gwe,
    input logic               i_rst,
    input lc4_isa_pkg::word_t i_cur_pc,
    input lc4_pipe_pkg::wb_t  i_retire
);

    // PC steps by one once the first cycle after reset has passed
    pc_step: assert property (@(posedge gwe) disable iff (i_rst)
        !$past(i_rst) |-> (i_cur_pc == $past(i_cur_pc) + 16'd1))
        else $error("o_cur_pc did not advance by one");

    // An empty slot never writes the register file
    we_valid: assert property (@(posedge gwe) disable iff (i_rst)
        i_retire.regfile_we |-> i_retire.valid)
        else $error("o_retire.regfile_we high without o_retire.valid");

    // In-order retirement with no gaps
    pc_order: assert property (@(posedge gwe) disable iff (i_rst)
        (i_retire.valid && $past(i_retire.valid))
            |-> (i_retire.pc == $past(i_retire.pc) + 16'd1))
        else $error("o_retire.pc out of sequence");

endmodule

bind lc4_core lc4_core_asserts u_asserts (
    .gwe      (gwe),
    .i_rst    (i_rst),
    .i_cur_pc (o_cur_pc),
    .i_retire (o_retire)
);

/* dv/lc4_core_tb.sv */
`timescale 1ns/100ps

module lc4_core_tb;

    localparam int CLK_PERIOD      = 10;
    localparam int DRIVE_DELAY     = 1;   // Inputs move 1 ns after the rising edge
    localparam int RST_CYCLES      = 2;
    localparam int PIPE_DEPTH      = 4;   // Fetch to retire latency
    localparam int PROG_LEN        = 400;
    localparam int WATCHDOG_CYCLES = RST_CYCLES + PIPE_DEPTH + PROG_LEN + 20;

    // Kept CONST held on i_cur_insn during reset so the empty slots carry a write
    localparam lc4_isa_pkg::word_t RST_INSN = {lc4_isa_pkg::OPC_CONST, 3'd1, 9'h0a5};

    logic               gwe;
    logic               i_rst;
    lc4_isa_pkg::word_t o_cur_pc;
    lc4_isa_pkg::word_t i_cur_insn;
    lc4_pipe_pkg::wb_t  o_retire;

    lc4_isa_pkg::word_t prog [PROG_LEN];                          // Instruction memory image
    lc4_isa_pkg::word_t model_regs [lc4_pipe_pkg::NUM_REGS];      // Reference register file
    integer             seed;

    lc4_core uut (
        .gwe        (gwe),
        .i_rst      (i_rst),
        .o_cur_pc   (o_cur_pc),
        .i_cur_insn (i_cur_insn),
        .o_retire   (o_retire)
    );

    always #(CLK_PERIOD / 2) gwe = ~gwe;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            $display("Something failed");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    // Mostly r0..r3 so neighbours depend on each other
    function automatic lc4_isa_pkg::reg_sel_t pick_reg();
        logic [31:0] r;
        r = $random(seed);
        if (r[3:0] < 4'd13) return {1'b0, r[5:4]};
        return r[6:4];
    endfunction

    function automatic lc4_isa_pkg::word_t random_insn();
        logic [31:0]           cat;
        logic [31:0]           f;
        lc4_isa_pkg::reg_sel_t rd;
        lc4_isa_pkg::reg_sel_t rs;
        lc4_isa_pkg::reg_sel_t rt;
        logic [3:0]            opc;
        cat = $random(seed);
        f   = $random(seed);
        rd  = pick_reg();
        rs  = pick_reg();
        rt  = pick_reg();
        if ((cat % 32'd100) < 32'd85) begin  // Kept instruction
            case (f % 32'd10)
                0: return {lc4_isa_pkg::OPC_ARITH, rd, rs, lc4_isa_pkg::SUB_ADD, rt};
                1: return {lc4_isa_pkg::OPC_ARITH, rd, rs, lc4_isa_pkg::SUB_SUB, rt};
                2: return {lc4_isa_pkg::OPC_ARITH, rd, rs, lc4_isa_pkg::SUB_MUL, rt};
                3: return {lc4_isa_pkg::OPC_ARITH, rd, rs, 1'b1, f[20:16]};
                4: return {lc4_isa_pkg::OPC_LOGIC, rd, rs, lc4_isa_pkg::SUB_AND, rt};
                5: return {lc4_isa_pkg::OPC_LOGIC, rd, rs, lc4_isa_pkg::SUB_NOT, rt};
                6: return {lc4_isa_pkg::OPC_LOGIC, rd, rs, lc4_isa_pkg::SUB_OR, rt};
                7: return {lc4_isa_pkg::OPC_LOGIC, rd, rs, lc4_isa_pkg::SUB_XOR, rt};
                8: return {lc4_isa_pkg::OPC_LOGIC, rd, rs, 1'b1, f[20:16]};
                default: return {lc4_isa_pkg::OPC_CONST, rd, f[24:16]};
            endcase
        end
        if (cat[7]) return {lc4_isa_pkg::OPC_ARITH, rd, rs, 3'b011, rt};  // DIV
        opc = f[11:8];
        if (opc == lc4_isa_pkg::OPC_ARITH || opc == lc4_isa_pkg::OPC_LOGIC ||
            opc == lc4_isa_pkg::OPC_CONST) begin
            opc = opc ^ 4'b0010;             // Move off the kept opcodes
        end
        return {opc, f[27:16]};
    endfunction

    task automatic build_program();
        logic [8:0] idx;
        prog[0] = {lc4_isa_pkg::OPC_CONST, 3'd1, 9'd128};                          // r1 = 0x80
        prog[1] = {lc4_isa_pkg::OPC_ARITH, 3'd3, 3'd1, lc4_isa_pkg::SUB_ADD, 3'd1}; // 0x100
        prog[2] = {lc4_isa_pkg::OPC_ARITH, 3'd3, 3'd3, lc4_isa_pkg::SUB_MUL, 3'd1}; // 0x8000
        prog[3] = {lc4_isa_pkg::OPC_ARITH, 3'd2, 3'd3, lc4_isa_pkg::SUB_SUB, 3'd3}; // Zero
        prog[4] = {lc4_isa_pkg::OPC_ARITH, 3'd0, 3'd1, 1'b1, 5'b11101};              // r1 - 3
        prog[5] = {lc4_isa_pkg::OPC_CONST, 3'd4, 9'h138};                           // -200
        for (idx = 9'd6; idx < 9'(PROG_LEN); idx++) begin
            prog[idx] = random_insn();
        end
    endtask

    // Combinational instruction memory that reads zero past the end of the program
    function automatic lc4_isa_pkg::word_t prog_word(input lc4_isa_pkg::word_t offset);
        if (offset < 16'(PROG_LEN)) return prog[offset[8:0]];
        return '0;
    endfunction

    // In-order ISA model executing one instruction per call
    task automatic model_execute(input lc4_isa_pkg::word_t w, output logic we,
                                 output lc4_isa_pkg::reg_sel_t rd,
                                 output lc4_isa_pkg::word_t res);
        lc4_isa_pkg::insn_u u;
        lc4_isa_pkg::word_t a;
        lc4_isa_pkg::word_t b;
        logic [31:0]        prod;
        u    = w;
        a    = model_regs[u.rr.rs];
        b    = model_regs[u.rr.rt];
        prod = 32'(a) * 32'(b);
        we   = 1'b1;
        rd   = u.rr.rd;
        res  = '0;
        case (u.rr.opcode)
            lc4_isa_pkg::OPC_ARITH: begin
                if (u.ri.imm_flag) res = a + 16'($signed(u.ri.imm5));
                else if (u.rr.sub == lc4_isa_pkg::SUB_ADD) res = a + b;
                else if (u.rr.sub == lc4_isa_pkg::SUB_MUL) res = prod[15:0];
                else if (u.rr.sub == lc4_isa_pkg::SUB_SUB) res = a - b;
                else we = 1'b0;                                   // DIV is not kept
            end
            lc4_isa_pkg::OPC_LOGIC: begin
                if (u.ri.imm_flag) res = a & 16'($signed(u.ri.imm5));
                else if (u.rr.sub == lc4_isa_pkg::SUB_AND) res = a & b;
                else if (u.rr.sub == lc4_isa_pkg::SUB_NOT) res = ~a;
                else if (u.rr.sub == lc4_isa_pkg::SUB_OR) res = a | b;
                else res = a ^ b;
            end
            lc4_isa_pkg::OPC_CONST: res = 16'($signed(u.ci.imm9));
            default: we = 1'b0;
        endcase
        if (we) model_regs[rd] = res;
    endtask

    function automatic lc4_isa_pkg::nzp_t expected_nzp(input lc4_isa_pkg::word_t v);
        if (v[15]) return 3'b100;
        if (v == 16'h0000) return 3'b010;
        return 3'b001;
    endfunction

    initial begin
        int                    cycle;
        int                    retired;
        logic                  exp_we;
        lc4_isa_pkg::reg_sel_t exp_rd;
        lc4_isa_pkg::word_t    exp_res;
        gwe        = 1'b0;
        i_rst      = 1'b1;
        i_cur_insn = RST_INSN;
        seed       = 32'hd567;
        model_regs = '{default: '0};
        build_program();
        repeat (RST_CYCLES) @(posedge gwe);
        #DRIVE_DELAY;
        i_rst   = 1'b0;
        cycle   = 0;
        retired = 0;
        while (retired < PROG_LEN) begin
            check_value("o_cur_pc", 32'(o_cur_pc), 32'(lc4_pipe_pkg::RESET_PC + 16'(cycle)));
            if (cycle < PIPE_DEPTH) begin    // Pipeline still filling
                check_value("o_retire.valid", 32'(o_retire.valid), 32'd0);
                check_value("o_retire.regfile_we", 32'(o_retire.regfile_we), 32'd0);
            end else begin
                check_value("o_retire.valid", 32'(o_retire.valid), 32'd1);
                check_value("o_retire.pc", 32'(o_retire.pc),
                            32'(lc4_pipe_pkg::RESET_PC + 16'(retired)));
                check_value("o_retire.insn", 32'(o_retire.insn),
                            32'(prog_word(16'(retired))));
                model_execute(prog_word(16'(retired)), exp_we, exp_rd, exp_res);
                check_value("o_retire.regfile_we", 32'(o_retire.regfile_we), 32'(exp_we));
                if (exp_we) begin
                    check_value("o_retire.rd", 32'(o_retire.rd), 32'(exp_rd));
                    check_value("o_retire.result", 32'(o_retire.result), 32'(exp_res));
                    check_value("o_retire.nzp", 32'(o_retire.nzp), 32'(expected_nzp(exp_res)));
                end
                retired++;
            end
            i_cur_insn = prog_word(o_cur_pc - lc4_pipe_pkg::RESET_PC);
            cycle++;
            @(posedge gwe);
            #DRIVE_DELAY;
        end
        $display("Everything OK");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: instruction retirement stalled before the program finished");
        $display("Something failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

/* verilog.f */
src/lc4_isa_pkg.sv
src/lc4_pipe_pkg.sv
src/lc4_alu.sv
src/lc4_decoder.sv
src/lc4_regfile.sv
src/lc4_fetch.sv
src/lc4_decode_stage.sv
src/lc4_execute.sv
src/lc4_writeback.sv
src/lc4_core.sv
dv/lc4_core_asserts.sv
dv/lc4_core_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log
verilator --binary --timing --assert --timescale 1ns/100ps --top-module lc4_core_tb \
    -f verilog.f -o lc4_core_sim \
    && { ./obj_dir/lc4_core_sim > sim.log 2>&1 || echo "Something failed" >> sim.log; } \
    || echo "Something failed" > sim.log
cat sim.log
grep -q "Something failed" sim.log && exit 1 || exit 0
